// File: Bender.yml
package:
  name: audio_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/audio_pkg.sv
      - hw/i2s_pkg.sv
      - hw/sample_if.sv
      - hw/audio_mixer.sv
      - hw/sample_fifo.sv
      - hw/i2s_transmitter.sv
      - hw/audio_core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/audio_core_chk.sv
      - test/audio_core_tb.sv

// File: flist.f
+incdir+hw
hw/audio_pkg.sv
hw/i2s_pkg.sv
hw/sample_if.sv
hw/audio_mixer.sv
hw/sample_fifo.sv
hw/i2s_transmitter.sv
hw/audio_core_top.sv
test/audio_core_chk.sv
test/audio_core_tb.sv

// File: hw/audio_core_top.sv
// Audio core top level: mixer, frame FIFO and I2S transmitter joined by two frame links
`timescale 1ns/10ps

module audio_core_top (
    input  logic                    clk_logic_w,
    input  logic                    system_reset_n_w,
    input  logic                    speaker_i,
    input  audio_pkg::card_audio_t  ssp_audio_i,
    input  audio_pkg::card_audio_t  mb_audio_l_i,
    input  audio_pkg::card_audio_t  mb_audio_r_i,
    input  logic                    enable_i,
    output logic                    i2s_bclk_o,
    output logic                    i2s_lrclk_o,
    output logic                    i2s_data_o,
    output audio_pkg::drop_count_t  dropped_count_o
);

    // Mixer to FIFO
    sample_if mix_if (
        .clk (clk_logic_w)
    );

    // FIFO to transmitter
    sample_if out_if (
        .clk (clk_logic_w)
    );

    audio_mixer u_audio_mixer (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .speaker_i        (speaker_i),
        .ssp_audio_i      (ssp_audio_i),
        .mb_audio_l_i     (mb_audio_l_i),
        .mb_audio_r_i     (mb_audio_r_i),
        .mix_src          (mix_if.src),
        .dropped_count_o  (dropped_count_o)
    );

    sample_fifo u_sample_fifo (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .wr_snk           (mix_if.snk),
        .rd_src           (out_if.src)
    );

    i2s_transmitter u_i2s_transmitter (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .enable_i         (enable_i),
        .frame_snk        (out_if.snk),
        .i2s_bclk_o       (i2s_bclk_o),
        .i2s_lrclk_o      (i2s_lrclk_o),
        .i2s_data_o       (i2s_data_o)
    );

endmodule

// File: hw/audio_defines.svh
// Audio core macros: sample and card widths, extension shifts, FIFO depth, I2S divider, sample period
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Output sample width, signed
`define AUDIO_SAMPLE_W 16

// Card audio level width, unsigned
`define AUDIO_CARD_W 10

// Card levels land in bits 12:3 of a sample
`define AUDIO_CARD_SHIFT 3

// Speaker bit lands on bit 12
`define AUDIO_SPK_SHIFT 12

// Frames buffered between mixer and transmitter
`define AUDIO_FIFO_DEPTH 4

// Clock cycles per BCLK half period
`define I2S_BCLK_DIV 2

// Clock cycles between sample ticks, longer than one 128 cycle I2S frame
`define AUDIO_SAMPLE_PERIOD 160

`endif

// File: hw/audio_mixer.sv
// Audio mixer: sample tick generator, card source extension and summing, frame handshake, drop counter
`timescale 1ns/10ps
`include "audio_defines.svh"

module audio_mixer (
    input  logic                     clk_logic_w,
    input  logic                     system_reset_n_w,
    input  logic                     speaker_i,
    input  audio_pkg::card_audio_t   ssp_audio_i,
    input  audio_pkg::card_audio_t   mb_audio_l_i,
    input  audio_pkg::card_audio_t   mb_audio_r_i,
    sample_if.src                    mix_src,
    output audio_pkg::drop_count_t   dropped_count_o
);

    localparam int PERIOD = `AUDIO_SAMPLE_PERIOD;
    localparam int TICK_W = $clog2(PERIOD);

    logic [TICK_W-1:0]         tick_cnt_r;
    logic                      tick_w;
    logic                      open_w;
    logic                      req_r;
    audio_pkg::drop_count_t    drop_cnt_r;
    audio_pkg::stereo_frame_t  frame_r;
    audio_pkg::stereo_frame_t  mixed_w;

    // Extended sources, all unsigned values in a 16 bit signed container
    audio_pkg::sample_t        spk_ext_w;
    audio_pkg::sample_t        ssp_ext_w;
    audio_pkg::sample_t        mb_l_ext_w;
    audio_pkg::sample_t        mb_r_ext_w;

    assign spk_ext_w  = audio_pkg::sample_t'(speaker_i) << `AUDIO_SPK_SHIFT;
    assign ssp_ext_w  = audio_pkg::sample_t'(ssp_audio_i) << `AUDIO_CARD_SHIFT;
    assign mb_l_ext_w = audio_pkg::sample_t'(mb_audio_l_i) << `AUDIO_CARD_SHIFT;
    assign mb_r_ext_w = audio_pkg::sample_t'(mb_audio_r_i) << `AUDIO_CARD_SHIFT;

    // Peak sum is 20464, no overflow possible
    assign mixed_w.left  = ssp_ext_w + mb_l_ext_w + spk_ext_w;
    assign mixed_w.right = ssp_ext_w + mb_r_ext_w + spk_ext_w;

    // Free running tick, first one a full period after reset
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            tick_cnt_r <= '0;
        end else if (tick_w) begin
            tick_cnt_r <= '0;
        end else begin
            tick_cnt_r <= tick_cnt_r + 1'b1;
        end
    end

    assign tick_w = (tick_cnt_r == TICK_W'(PERIOD - 1));

    // A handshake is open until both req and ack are back low
    assign open_w = req_r || mix_src.ack;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            req_r      <= 1'b0;
            drop_cnt_r <= '0;
        end else begin
            if (tick_w && open_w) begin
                drop_cnt_r <= drop_cnt_r + 1'b1;  // Pending frame not taken yet
            end else if (tick_w) begin
                req_r <= 1'b1;
            end
            if (req_r && mix_src.ack) begin
                req_r <= 1'b0;
            end
        end
    end

    // Frame held stable for the whole handshake
    always_ff @(posedge clk_logic_w) begin
        if (tick_w && !open_w) begin
            frame_r <= mixed_w;
        end
    end

    assign mix_src.req     = req_r;
    assign mix_src.frame   = frame_r;
    assign dropped_count_o = drop_cnt_r;

endmodule

// File: hw/audio_pkg.sv
// Audio package: sample, card level, stereo frame and drop counter types
`include "audio_defines.svh"

package audio_pkg;

    // One output sample, two's complement
    typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

    // Raw level from a slot card
    typedef logic [`AUDIO_CARD_W-1:0] card_audio_t;

    // Left word sits in the upper half, matching I2S send order
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_frame_t;

    // Dropped frame count, wraps
    typedef logic [15:0] drop_count_t;

endpackage

// File: hw/i2s_pkg.sv
// I2S package: transmitter state and bit position types, last bit position
package i2s_pkg;

    // Transmitter FSM states
    typedef enum logic [1:0] {
        TX_IDLE,   // Clocks held low, waiting for enable and a frame
        TX_FETCH,  // One cycle handshake slot before a frame boundary
        TX_SHIFT   // Serial output running
    } tx_state_t;

    // Position within a 32 bit stereo frame
    typedef logic [4:0] bit_index_t;

    // Final slot of a frame, right word LSB
    localparam bit_index_t LAST_BIT = 5'd31;

endpackage

// File: hw/i2s_transmitter.sv
// I2S transmitter: BCLK and LRCLK generation, frame fetch FSM, MSB first serial shifting
`timescale 1ns/10ps
`include "audio_defines.svh"

module i2s_transmitter (
    input  logic  clk_logic_w,
    input  logic  system_reset_n_w,
    input  logic  enable_i,
    sample_if.snk frame_snk,
    output logic  i2s_bclk_o,
    output logic  i2s_lrclk_o,
    output logic  i2s_data_o
);

    localparam int DIV     = `I2S_BCLK_DIV;
    localparam int DIV_W   = (DIV > 1) ? $clog2(DIV) : 1;
    localparam int FRAME_W = $bits(audio_pkg::stereo_frame_t);

    i2s_pkg::tx_state_t        state_r;
    i2s_pkg::bit_index_t       bit_idx_r;   // Slot currently on the data line
    i2s_pkg::bit_index_t       next_idx_w;
    logic [DIV_W-1:0]          div_r;
    logic                      edge_w;
    logic                      rise_w;
    logic                      fall_w;
    logic                      bclk_r;
    logic                      lrclk_r;
    logic                      data_r;
    logic                      ack_r;
    logic                      stop_r;      // Stop after the current frame
    logic                      fetch_ok_w;
    logic [FRAME_W-1:0]        shift_r;
    audio_pkg::stereo_frame_t  next_frame_r;

    assign edge_w     = (div_r == DIV_W'(DIV - 1));
    assign rise_w     = edge_w && !bclk_r;
    assign fall_w     = edge_w && bclk_r;
    assign next_idx_w = bit_idx_r + 1'b1;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            state_r   <= i2s_pkg::TX_IDLE;
            bit_idx_r <= i2s_pkg::LAST_BIT;
            div_r     <= '0;
            bclk_r    <= 1'b0;
            lrclk_r   <= 1'b0;
            data_r    <= 1'b0;
            shift_r   <= '0;
            stop_r    <= 1'b0;
        end else begin
            case (state_r)
                i2s_pkg::TX_IDLE: begin
                    // Clocks start only once a frame is waiting
                    if (enable_i && frame_snk.req) begin
                        state_r <= i2s_pkg::TX_SHIFT;
                    end
                end
                i2s_pkg::TX_FETCH: begin
                    state_r <= i2s_pkg::TX_SHIFT;
                    stop_r  <= !enable_i;
                end
                default: begin
                    if (rise_w && bit_idx_r == i2s_pkg::LAST_BIT) begin
                        state_r <= i2s_pkg::TX_FETCH;  // Half a BCLK before the boundary
                    end
                end
            endcase

            if (state_r != i2s_pkg::TX_IDLE) begin
                div_r <= edge_w ? '0 : div_r + 1'b1;
                if (edge_w) begin
                    bclk_r <= !bclk_r;
                end
                if (fall_w && stop_r && bit_idx_r == '0) begin
                    // Right LSB went out on the last rising edge
                    state_r   <= i2s_pkg::TX_IDLE;
                    bit_idx_r <= i2s_pkg::LAST_BIT;
                    lrclk_r   <= 1'b0;
                    data_r    <= 1'b0;
                    shift_r   <= '0;
                    stop_r    <= 1'b0;
                end else if (fall_w) begin
                    bit_idx_r <= next_idx_w;
                    lrclk_r   <= next_idx_w[4];      // High for the right word
                    data_r    <= shift_r[FRAME_W-1]; // One slot behind LRCLK
                    if (next_idx_w == '0) begin
                        shift_r <= next_frame_r;
                    end else begin
                        shift_r <= {shift_r[FRAME_W-2:0], 1'b0};
                    end
                end
            end
        end
    end

    // Take a frame only on a fresh request
    assign fetch_ok_w = enable_i && frame_snk.req && !ack_r;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            ack_r <= 1'b0;
        end else if (state_r == i2s_pkg::TX_FETCH && fetch_ok_w) begin
            ack_r <= 1'b1;
        end else if (!frame_snk.req) begin
            ack_r <= 1'b0;
        end
    end

    // Silence when the FIFO has nothing
    always_ff @(posedge clk_logic_w) begin
        if (state_r == i2s_pkg::TX_FETCH) begin
            next_frame_r <= fetch_ok_w ? frame_snk.frame : '0;
        end
    end

    assign frame_snk.ack = ack_r;
    assign i2s_bclk_o    = bclk_r;
    assign i2s_lrclk_o   = lrclk_r;
    assign i2s_data_o    = data_r;

endmodule

// File: hw/sample_fifo.sv
// Frame FIFO: circular buffer with handshake sink on the write side and source on the read side
`timescale 1ns/10ps
`include "audio_defines.svh"

module sample_fifo #(
    parameter int DEPTH = `AUDIO_FIFO_DEPTH
) (
    input  logic  clk_logic_w,
    input  logic  system_reset_n_w,
    sample_if.snk wr_snk,
    sample_if.src rd_src
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    audio_pkg::stereo_frame_t  mem_r [DEPTH];
    logic [PTR_W-1:0]          wr_ptr_r;
    logic [PTR_W-1:0]          rd_ptr_r;
    logic [CNT_W-1:0]          count_r;
    logic                      full_w;
    logic                      empty_w;
    logic                      wr_ack_r;
    logic                      rd_req_r;
    logic                      wr_take_w;
    logic                      rd_done_w;

    assign full_w  = (count_r == CNT_W'(DEPTH));
    assign empty_w = (count_r == '0);

    // New request only, and only with room to store it
    assign wr_take_w = wr_snk.req && !wr_ack_r && !full_w;
    assign rd_done_w = rd_req_r && rd_src.ack;

    // Write side, ack withheld while full
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            wr_ack_r <= 1'b0;
            wr_ptr_r <= '0;
        end else if (wr_take_w) begin
            wr_ack_r <= 1'b1;
            wr_ptr_r <= wr_ptr_r + 1'b1;  // Wraps for power of two depths
        end else if (!wr_snk.req) begin
            wr_ack_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (wr_take_w) begin
            mem_r[wr_ptr_r] <= wr_snk.frame;
        end
    end

    // Read side, offer the head once the previous handshake closed
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            rd_req_r <= 1'b0;
            rd_ptr_r <= '0;
        end else if (rd_done_w) begin
            rd_req_r <= 1'b0;
            rd_ptr_r <= rd_ptr_r + 1'b1;
        end else if (!rd_req_r && !rd_src.ack && !empty_w) begin
            rd_req_r <= 1'b1;
        end
    end

    // Occupancy
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            count_r <= '0;
        end else begin
            case ({wr_take_w, rd_done_w})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;  // Both or neither
            endcase
        end
    end

    assign wr_snk.ack   = wr_ack_r;
    assign rd_src.req   = rd_req_r;
    assign rd_src.frame = mem_r[rd_ptr_r];  // Head stays put until ack

endmodule

// File: hw/sample_if.sv
// Stereo frame link interface with four-phase req/ack handshake and its modports
`timescale 1ns/10ps

interface sample_if (
    input logic clk
);

    logic                      req;    // Frame offered, held until ack
    logic                      ack;    // Frame taken, held until req drops
    audio_pkg::stereo_frame_t  frame;  // Stable while req is high

    // Producer side
    modport src (
        input  clk,
        output req,
        output frame,
        input  ack
    );

    // Consumer side
    modport snk (
        input  clk,
        input  req,
        input  frame,
        output ack
    );

endinterface

// File: test/audio_core_chk.sv
// Bound checker for audio_core_top: frame link handshake and I2S framing assertions
`timescale 1ns/10ps

module audio_core_chk (
    input logic clk_logic_w,
    input logic system_reset_n_w,
    input logic mix_req_i,
    input logic mix_ack_i,
    input logic out_req_i,
    input logic out_ack_i,
    input logic bclk_i,
    input logic lrclk_i
);

    int fail_cnt = 0;  // Read by the testbench at the end of the run

    // req stays up until the sink has acked
    a_mix_req_held: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        mix_req_i && !mix_ack_i |=> mix_req_i)
        else begin $error("mix link req fell before ack"); fail_cnt++; end

    a_out_req_held: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        out_req_i && !out_ack_i |=> out_req_i)
        else begin $error("out link req fell before ack"); fail_cnt++; end

    // ack answers a request seen the cycle before
    a_mix_ack_req: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        $rose(mix_ack_i) |-> $past(mix_req_i))
        else begin $error("mix link ack rose without req"); fail_cnt++; end

    a_out_ack_req: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        $rose(out_ack_i) |-> $past(out_req_i))
        else begin $error("out link ack rose without req"); fail_cnt++; end

    // Word select moves with the falling BCLK edge only
    a_lrclk_edge: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        $changed(lrclk_i) |-> $fell(bclk_i))
        else begin $error("LRCLK changed away from a BCLK fall"); fail_cnt++; end

endmodule

bind audio_core_top audio_core_chk u_audio_core_chk (
    .clk_logic_w      (clk_logic_w),
    .system_reset_n_w (system_reset_n_w),
    .mix_req_i        (mix_if.req),
    .mix_ack_i        (mix_if.ack),
    .out_req_i        (out_if.req),
    .out_ack_i        (out_if.ack),
    .bclk_i           (i2s_bclk_o),
    .lrclk_i          (i2s_lrclk_o)
);

// File: test/audio_core_tb.sv
// Testbench with clock, reset, stimulus table, I2S capture, compare tasks and timeout
`timescale 1ns/10ps
`include "audio_defines.svh"

module audio_core_tb;

    localparam int PERIOD   = `AUDIO_SAMPLE_PERIOD;
    localparam int HOLD     = `AUDIO_FIFO_DEPTH + 1;  // FIFO plus the mixer's pending frame
    localparam int ENTRIES  = 60;
    localparam int LIMIT    = (ENTRIES + 20) * PERIOD;
    localparam int G_RESET  = 0;
    localparam int G_FIXED  = 1;
    localparam int G_RANDOM = 2;
    localparam int G_BACKP  = 3;
    localparam int G_RECOV  = 4;

    typedef struct {
        logic                    spk;
        audio_pkg::card_audio_t  ssp;
        audio_pkg::card_audio_t  mbl;
        audio_pkg::card_audio_t  mbr;
        logic                    en;
        int                      grp;
        audio_pkg::sample_t      exp_l;
        audio_pkg::sample_t      exp_r;
    } entry_t;

    logic                    clk_logic_w;
    logic                    system_reset_n_w;
    logic                    speaker_i;
    audio_pkg::card_audio_t  ssp_audio_i;
    audio_pkg::card_audio_t  mb_audio_l_i;
    audio_pkg::card_audio_t  mb_audio_r_i;
    logic                    enable_i;
    logic                    i2s_bclk_o;
    logic                    i2s_lrclk_o;
    logic                    i2s_data_o;
    audio_pkg::drop_count_t  dropped_count_o;

    entry_t                    table_r [ENTRIES];
    audio_pkg::drop_count_t    drops_after [ENTRIES];
    audio_pkg::stereo_frame_t  exp_q [$];
    int                        exp_grp_q [$];
    int                        checks [5];
    int                        errs [5];
    int                        exp_cnt [5];
    int                        rx_cnt [5];
    int                        rx_total = 0;
    int                        exp_total = 0;
    int                        cycle_cnt = 0;
    string                     names [5] = '{"reset", "fixed", "random", "backpressure",
                                             "recovery"};

    audio_core_top u_audio_core_top (.*);

    always #20 clk_logic_w = ~clk_logic_w;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Card levels weigh 8 and the speaker bit 4096
    function automatic audio_pkg::sample_t mix_rule(input logic spk,
            input audio_pkg::card_audio_t ssp, input audio_pkg::card_audio_t mb);
        return audio_pkg::sample_t'((int'(ssp) << `AUDIO_CARD_SHIFT)
            + (int'(mb) << `AUDIO_CARD_SHIFT) + (int'(spk) << `AUDIO_SPK_SHIFT));
    endfunction

    task automatic build_table();
        logic [31:0]               rng;
        int                        run;
        int                        drops;
        audio_pkg::stereo_frame_t  f;
        rng = 32'h33edcb11;
        table_r[0] = '{1'b0, 10'd0, 10'd0, 10'd0, 1'b1, G_FIXED, 16'sd0, 16'sd0};
        table_r[1] = '{1'b1, 10'd0, 10'd0, 10'd0, 1'b1, G_FIXED, 16'sd4096, 16'sd4096};
        table_r[2] = '{1'b1, 10'd1023, 10'd1023, 10'd1023, 1'b1, G_FIXED,
                       16'sd20464, 16'sd20464};
        table_r[3] = '{1'b0, 10'd100, 10'd300, 10'd50, 1'b1, G_FIXED, 16'sd3200, 16'sd1200};
        for (int j = 4; j < ENTRIES; j++) begin
            rng = xorshift(rng);
            table_r[j].spk   = rng[31];
            table_r[j].ssp   = rng[9:0];
            table_r[j].mbl   = rng[19:10];
            table_r[j].mbr   = rng[29:20];
            table_r[j].en    = !(j >= 44 && j < 54);  // Ten ticks with the transmitter off
            table_r[j].grp   = (j < 44) ? G_RANDOM : (j < 54) ? G_BACKP : G_RECOV;
            table_r[j].exp_l = mix_rule(table_r[j].spk, table_r[j].ssp, table_r[j].mbl);
            table_r[j].exp_r = mix_rule(table_r[j].spk, table_r[j].ssp, table_r[j].mbr);
        end
        run   = 0;
        drops = 0;
        foreach (table_r[j]) begin
            run = table_r[j].en ? 0 : run + 1;
            f.left  = table_r[j].exp_l;
            f.right = table_r[j].exp_r;
            if (run > HOLD) begin
                drops++;
            end else begin
                exp_q.push_back(f);
                exp_grp_q.push_back(table_r[j].en ? table_r[j].grp : G_RECOV);  // Held frames
                exp_cnt[exp_grp_q[$]]++;
                exp_total++;
            end
            drops_after[j] = audio_pkg::drop_count_t'(drops);
        end
    endtask

    task automatic report_test(input int g);
        $display("Test %s: %0d checks, %0d errors", names[g], checks[g], errs[g]);
    endtask

    task automatic check_frame(input audio_pkg::stereo_frame_t got,
            input audio_pkg::stereo_frame_t exp, input int g);
        checks[g]++;
        if (got !== exp) begin
            errs[g]++;
            $display("** Error at %0t: %s frame got L=%0d R=%0d, expected L=%0d R=%0d",
                $time, names[g], got.left, got.right, exp.left, exp.right);
        end
    endtask

    task automatic check_drops(input audio_pkg::drop_count_t got,
            input audio_pkg::drop_count_t exp, input int g);
        checks[g]++;
        if (got !== exp) begin
            errs[g]++;
            $display("** Error at %0t: %s drop count %0d, expected %0d",
                $time, names[g], got, exp);
        end
    endtask

    task automatic check_idle(input logic bclk, input logic lrclk, input logic data);
        checks[G_RESET]++;
        if ({bclk, lrclk, data} !== 3'b000) begin
            errs[G_RESET]++;
            $display("** Error at %0t: I2S outputs %b%b%b, expected all low before first tick",
                $time, bclk, lrclk, data);
        end
    endtask

    // Outputs and drop count must stay at rest while idle is set
    task automatic wait_cycles(input int n, input bit idle);
        for (int c = 0; c < n; c++) begin
            @(posedge clk_logic_w);
            if (idle) begin
                check_idle(i2s_bclk_o, i2s_lrclk_o, i2s_data_o);
                check_drops(dropped_count_o, '0, G_RESET);
            end
        end
    endtask

    task automatic take_frame(input audio_pkg::stereo_frame_t got);
        int g;
        if (exp_q.size() == 0) begin
            checks[G_RECOV]++;
            errs[G_RECOV]++;
            $display("A frame arrived after all expected frames were received");
        end else begin
            g = exp_grp_q.pop_front();
            check_frame(got, exp_q.pop_front(), g);
            rx_cnt[g]++;
            rx_total++;
            if (g != G_RECOV && rx_cnt[g] == exp_cnt[g]) begin
                report_test(g);
            end
        end
    endtask

    // I2S capture where out link acks tell real frames from silent fill
    always @(posedge clk_logic_w) begin
        static logic         bclk_q = 1'b0;
        static logic         ack_q = 1'b0;
        static logic         lr_slot = 1'b0;
        static logic [31:0]  sh = '0;
        static int           idle_cnt = 0;
        static int           acks = 0;
        static bit           fresh = 1'b1;   // First frame after the clocks restart
        static bit           next_real = 1'b0;
        bit                  is_real;
        if (system_reset_n_w) begin
            if (u_audio_core_top.out_if.ack && !ack_q) begin
                acks++;
            end
            ack_q = u_audio_core_top.out_if.ack;
            idle_cnt = (i2s_bclk_o == bclk_q) ? idle_cnt + 1 : 0;
            if (idle_cnt >= 8) begin
                fresh = 1'b1;
            end
            if (i2s_bclk_o && !bclk_q) begin
                if (!i2s_lrclk_o && lr_slot) begin
                    is_real   = fresh ? 1'b1 : next_real;
                    next_real = fresh ? (acks >= 2) : (acks >= 1);
                    fresh     = 1'b0;
                    acks      = 0;
                    if (is_real) begin
                        take_frame({sh[30:0], i2s_data_o});
                    end
                end
                sh      = {sh[30:0], i2s_data_o};
                lr_slot = i2s_lrclk_o;
            end
            bclk_q = i2s_bclk_o;
        end
    end

    always @(posedge clk_logic_w) begin
        cycle_cnt++;
        if (cycle_cnt > LIMIT) begin
            $display("Timeout: run exceeded %0d cycles with %0d of %0d frames received",
                LIMIT, rx_total, exp_total);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int total_checks;
        int total_errs;
        clk_logic_w      = 1'b0;
        system_reset_n_w = 1'b0;
        speaker_i        = 1'b0;
        ssp_audio_i      = '0;
        mb_audio_l_i     = '0;
        mb_audio_r_i     = '0;
        enable_i         = 1'b1;
        build_table();
        repeat (4) @(posedge clk_logic_w);
        system_reset_n_w <= 1'b1;
        wait_cycles(PERIOD / 2, 1'b1);
        // Inputs change midway between ticks
        for (int j = 0; j < ENTRIES; j++) begin
            if (j > 0) begin
                check_drops(dropped_count_o, drops_after[j-1], table_r[j-1].grp);
                if (table_r[j-1].grp == G_BACKP && table_r[j].grp != G_BACKP) begin
                    report_test(G_BACKP);
                end
            end
            speaker_i    <= table_r[j].spk;
            ssp_audio_i  <= table_r[j].ssp;
            mb_audio_l_i <= table_r[j].mbl;
            mb_audio_r_i <= table_r[j].mbr;
            if (table_r[j].en) begin
                enable_i <= 1'b1;
            end
            wait_cycles(PERIOD / 2 - 2, j == 0);  // Still idle up to the first tick
            if (j == 0) begin
                report_test(G_RESET);
            end
            if (!table_r[j].en) begin
                enable_i <= 1'b0;  // Just before the tick so the FIFO starts empty
            end
            wait_cycles(PERIOD / 2 + 2, 1'b0);
        end
        check_drops(dropped_count_o, drops_after[ENTRIES-1], G_RECOV);
        while (rx_total < exp_total) begin
            @(posedge clk_logic_w);
        end
        report_test(G_RECOV);
        total_checks = 0;
        total_errs   = u_audio_core_top.u_audio_core_chk.fail_cnt;
        for (int g = 0; g < 5; g++) begin
            total_checks += checks[g];
            total_errs   += errs[g];
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", total_checks,
            total_errs, u_audio_core_top.u_audio_core_chk.fail_cnt);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
